/* compile.f */
hdl/timer_pkg.sv
hdl/timer_counter.sv
hdl/timer_ctrl.sv
hdl/timer_regs.sv
hdl/timer.sv
test/tb_timer.sv

/* run_sim.sh */
#!/bin/sh
# build and run the timer testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
  -f compile.f \
  --top-module tb_timer \
  -o sim_timer

# the simulator exits nonzero on $fatal, the log decides the verdict
./obj_dir/sim_timer > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
  echo "simulation ended without a verdict, see $LOG"
  exit 1
fi

echo "simulation passed"
exit 0

/* test/tb_timer.sv */
`timescale 1ns/10ps

module tb_timer import timer_pkg::*; ();

  // ----------------------------------------
  // test sizing
  // ----------------------------------------

  localparam int CLK_HALF       = 20;
  localparam int DRIVE_DLY      = 5;
  localparam int SEED           = 21;
  localparam int P_MAX          = 3;
  localparam int T_MAX          = 20;
  localparam int PRESCALED_RUNS = 4;
  // p zero run, prescaled runs, stop run
  localparam int NUM_RUNS       = PRESCALED_RUNS + 2;
  // worst case run length per run plus room for register traffic
  localparam int WATCHDOG_CYCLES =
    NUM_RUNS * (T_MAX * (P_MAX + 2) + P_MAX + 10) + 200;

  logic                   clk;
  logic                   reset_n;
  logic                   cs;
  logic                   we;
  logic [ADDR_WIDTH-1:0]  address;
  logic [TIMER_WIDTH-1:0] write_data;
  logic [TIMER_WIDTH-1:0] read_data;
  logic                   irq;

  timer i_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .irq        (irq)
  );

  // ----------------------------------------
  // clock and watchdog
  // ----------------------------------------

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the test hung", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog timeout");
  end

  // ----------------------------------------
  // failure reporting
  // ----------------------------------------

  task automatic abort_test(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped on first error");
  endtask

  task automatic value_error(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
             $time, name, expected, actual);
    abort_test("wrong value seen on the DUT");
  endtask

  // ----------------------------------------
  // host bus tasks
  // ----------------------------------------

  // called 5 ns after an edge and returns 5 ns after the write edge
  task automatic bus_write(input logic [ADDR_WIDTH-1:0] addr,
                           input logic [TIMER_WIDTH-1:0] data);
    cs         = 1'b1;
    we         = 1'b1;
    address    = addr;
    write_data = data;
    @(posedge clk);
    #DRIVE_DLY;
    cs         = 1'b0;
    we         = 1'b0;
    write_data = '0;
  endtask

  // read mux is combinational so data is sampled mid cycle
  task automatic bus_read(input logic [ADDR_WIDTH-1:0] addr,
                          output logic [TIMER_WIDTH-1:0] data);
    cs      = 1'b1;
    we      = 1'b0;
    address = addr;
    #(2 * DRIVE_DLY);
    data = read_data;
    @(posedge clk);
    #DRIVE_DLY;
    cs = 1'b0;
  endtask

  task automatic expect_read(input logic [ADDR_WIDTH-1:0] addr,
                             input logic [31:0] expected, input string name);
    logic [TIMER_WIDTH-1:0] data;
    bus_read(addr, data);
    assert (data == expected) else value_error(name, expected, data);
  endtask

  task automatic expect_running(input logic expected);
    logic [TIMER_WIDTH-1:0] data;
    bus_read(ADDR_STATUS, data);
    assert (data[STATUS_RUNNING_BIT] == expected)
      else value_error("status.running", expected, data[STATUS_RUNNING_BIT]);
  endtask

  // ----------------------------------------
  // run helpers
  // ----------------------------------------

  // edges from the ctrl write to irq high
  // one to load, the ticks, the last prescale phase, one for the flag
  function automatic int irq_latency(input int p, input int t);
    int tick;
    int last_prescale;
    tick          = (p == 0) ? 1 : p + 2;
    last_prescale = (p == 0) ? 0 : p + 1;
    return 1 + t * tick + last_prescale + 1;
  endfunction

  task automatic start_run(input int p, input int t);
    bus_write(ADDR_PRESCALER, p);
    bus_write(ADDR_TIMER, t);
    bus_write(ADDR_CTRL, 32'h1);
    // running still low in the pulse cycle and up one cycle later
    expect_running(1'b0);
    expect_running(1'b1);
  endtask

  // polls the live count every cycle until irq
  task automatic wait_expiry(input int p, input int t);
    logic [TIMER_WIDTH-1:0] prev;
    logic [TIMER_WIDTH-1:0] curr;
    int                     n;
    int                     expected;
    expected = irq_latency(p, t);
    // start_run already spent two cycles after the ctrl write
    n    = 2;
    prev = t;
    while (!irq) begin
      bus_read(ADDR_CURR, curr);
      n++;
      assert (curr <= prev) else value_error("curr_timer rising", prev, curr);
      assert (prev - curr <= 1) else value_error("curr_timer step", prev - 1, curr);
      prev = curr;
      if (n > expected + 8) begin
        abort_test("irq never rose within the expected run length");
      end
    end
    assert (n == expected) else value_error("irq latency in cycles", expected, n);
    expect_read(ADDR_CURR, '0, "curr_timer at expiry");
    // stopped with the expired bit set
    expect_read(ADDR_STATUS, 32'h2, "status at expiry");
  endtask

  task automatic clear_expiry();
    bus_write(ADDR_STATUS, 32'h2);
    assert (irq == 1'b0) else value_error("irq after clear", 0, irq);
    expect_read(ADDR_STATUS, '0, "status after clear");
  endtask

  // ----------------------------------------
  // protocol assertions
  // ----------------------------------------

  // read data stays zero without a read strobe
  a_read_idle_zero: assert property (
    @(posedge clk) disable iff (!reset_n)
    !(cs && !we) |-> (read_data == '0)
  ) else value_error("read_data without read", '0, read_data);

  // irq drops only on a write of one to the expired bit
  a_irq_clear_only: assert property (
    @(posedge clk) disable iff (!reset_n)
    $fell(irq) |->
      $past(cs && we && (address == ADDR_STATUS) && write_data[STATUS_EXPIRED_BIT])
  ) else abort_test("irq dropped without a clear write");

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  initial begin
    logic [TIMER_WIDTH-1:0] rnd;
    logic [TIMER_WIDTH-1:0] frozen;
    int                     p;
    int                     t;
    void'($urandom(SEED));
    reset_n    = 1'b0;
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    reset_n = 1'b1;

    // everything zero out of reset
    assert (irq == 1'b0) else value_error("irq after reset", 0, irq);
    expect_read(ADDR_STATUS, '0, "status");
    expect_read(ADDR_PRESCALER, '0, "prescaler_init");
    expect_read(ADDR_TIMER, '0, "timer_init");
    expect_read(ADDR_CURR, '0, "curr_timer");
    expect_read(ADDR_CTRL, '0, "ctrl");

    // full width readback then an unmapped address
    rnd = $urandom;
    bus_write(ADDR_PRESCALER, rnd);
    expect_read(ADDR_PRESCALER, rnd, "prescaler_init");
    rnd = $urandom;
    bus_write(ADDR_TIMER, rnd);
    expect_read(ADDR_TIMER, rnd, "timer_init");
    bus_write(8'h3f, 32'hdead_beef);
    expect_read(8'h3f, '0, "unmapped read");
    expect_read(ADDR_TIMER, rnd, "timer_init after unmapped write");

    // prescaler off gives one cycle per tick
    t = 2 + int'($urandom % (T_MAX - 1));
    start_run(0, t);
    wait_expiry(0, t);
    clear_expiry();

    // prescaled runs each cleared so the next one sets irq again
    for (int i = 0; i < PRESCALED_RUNS; i++) begin
      p = 1 + int'($urandom % P_MAX);
      t = 1 + int'($urandom % T_MAX);
      start_run(p, t);
      wait_expiry(p, t);
      clear_expiry();
    end

    // stop mid run while the count is still far from zero
    p = 1 + int'($urandom % P_MAX);
    t = 8 + int'($urandom % (T_MAX - 7));
    start_run(p, t);
    bus_write(ADDR_TIMER, 32'd99);
    expect_read(ADDR_TIMER, t, "timer_init locked while running");
    bus_write(ADDR_PRESCALER, 32'd7);
    expect_read(ADDR_PRESCALER, p, "prescaler_init locked while running");
    bus_write(ADDR_CTRL, 32'h1);
    expect_running(1'b1);
    expect_running(1'b0);
    bus_read(ADDR_CURR, frozen);
    if (frozen == '0) begin
      abort_test("count reached zero although the run was stopped early");
    end
    repeat (6) expect_read(ADDR_CURR, frozen, "curr_timer frozen");
    assert (irq == 1'b0) else value_error("irq after stop", 0, irq);
    bus_write(ADDR_TIMER, 32'd99);
    expect_read(ADDR_TIMER, 32'd99, "timer_init after stop");
    bus_write(ADDR_PRESCALER, 32'd2);
    expect_read(ADDR_PRESCALER, 32'd2, "prescaler_init after stop");

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* hdl/timer.sv */
`timescale 1ns/10ps

module timer import timer_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_n,
  // host strobe interface
  input  logic                   cs,
  input  logic                   we,
  input  logic [ADDR_WIDTH-1:0]  address,
  input  logic [TIMER_WIDTH-1:0] write_data,
  output logic [TIMER_WIDTH-1:0] read_data,
  // expiry interrupt
  output logic                   irq
);

  // ----------------------------------------
  // internal wiring
  // ----------------------------------------

  // register block to controller and counters
  logic [TIMER_WIDTH-1:0] prescaler_init;
  logic [TIMER_WIDTH-1:0] timer_init;
  logic                   start_stop;

  // controller to register block
  logic                   running;
  logic                   done;

  // controller to counters
  logic                   prescaler_load;
  logic                   prescaler_dec;
  logic                   timer_load;
  logic                   timer_dec;

  // counters back to controller
  logic                   prescaler_zero;
  logic                   timer_zero;
  logic [TIMER_WIDTH-1:0] curr_timer;

  // ----------------------------------------
  // host registers
  // ----------------------------------------

  timer_regs u_regs (
    .clk            (clk),
    .reset_n        (reset_n),
    .cs             (cs),
    .we             (we),
    .address        (address),
    .write_data     (write_data),
    .read_data      (read_data),
    .curr_timer     (curr_timer),
    .running        (running),
    .done           (done),
    .prescaler_init (prescaler_init),
    .timer_init     (timer_init),
    .start_stop     (start_stop),
    .irq            (irq)
  );

  // ----------------------------------------
  // sequencing
  // ----------------------------------------

  timer_ctrl u_ctrl (
    .clk            (clk),
    .reset_n        (reset_n),
    .start_stop     (start_stop),
    .prescaler_init (prescaler_init),
    .prescaler_zero (prescaler_zero),
    .timer_zero     (timer_zero),
    .prescaler_load (prescaler_load),
    .prescaler_dec  (prescaler_dec),
    .timer_load     (timer_load),
    .timer_dec      (timer_dec),
    .running        (running),
    .done           (done)
  );

  // ----------------------------------------
  // counters
  // ----------------------------------------

  // prescaler count is internal only, nothing reads it back
  timer_counter u_prescaler (
    .clk        (clk),
    .reset_n    (reset_n),
    .load       (prescaler_load),
    .dec        (prescaler_dec),
    .init_value (prescaler_init),
    .count      (),
    .zero       (prescaler_zero)
  );

  timer_counter u_timer (
    .clk        (clk),
    .reset_n    (reset_n),
    .load       (timer_load),
    .dec        (timer_dec),
    .init_value (timer_init),
    .count      (curr_timer),
    .zero       (timer_zero)
  );

endmodule

/* hdl/timer_regs.sv */
`timescale 1ns/10ps

module timer_regs import timer_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_n,
  // host strobe interface
  input  logic                   cs,
  input  logic                   we,
  input  logic [ADDR_WIDTH-1:0]  address,
  input  logic [TIMER_WIDTH-1:0] write_data,
  output logic [TIMER_WIDTH-1:0] read_data,
  // live timer count for readback
  input  logic [TIMER_WIDTH-1:0] curr_timer,
  // status from controller
  input  logic                   running,
  input  logic                   done,
  // config to controller and counters
  output logic [TIMER_WIDTH-1:0] prescaler_init,
  output logic [TIMER_WIDTH-1:0] timer_init,
  output logic                   start_stop,
  // interrupt follows the sticky expired flag
  output logic                   irq
);

  reg_addr_t addr;
  logic      wr_en;
  logic      rd_en;
  logic      wr_ctrl;
  logic      wr_status;
  logic      wr_prescaler;
  logic      wr_timer;
  logic      expired_reg;

  // ----------------------------------------
  // address decode
  // ----------------------------------------

  assign addr  = reg_addr_t'(address);
  assign wr_en = cs && we;
  assign rd_en = cs && !we;

  // unknown addresses match none of these
  assign wr_ctrl      = wr_en && (addr == ADDR_CTRL);
  assign wr_status    = wr_en && (addr == ADDR_STATUS);
  // init values locked while a run is active
  assign wr_prescaler = wr_en && (addr == ADDR_PRESCALER) && !running;
  assign wr_timer     = wr_en && (addr == ADDR_TIMER) && !running;

  // ----------------------------------------
  // control registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      prescaler_init <= '0;
      timer_init     <= '0;
      start_stop     <= 1'b0;
      expired_reg    <= 1'b0;
    end else begin
      if (wr_prescaler) begin
        prescaler_init <= write_data;
      end
      if (wr_timer) begin
        timer_init <= write_data;
      end

      // one-cycle pulse in the cycle after the write
      start_stop <= wr_ctrl && write_data[CTRL_START_BIT];

      // set on done beats write-one-to-clear
      if (done) begin
        expired_reg <= 1'b1;
      end else if (wr_status && write_data[STATUS_EXPIRED_BIT]) begin
        expired_reg <= 1'b0;
      end
    end
  end

  assign irq = expired_reg;

  // ----------------------------------------
  // read mux
  // ----------------------------------------

  // combinational read data is zero when not reading
  always_comb begin
    read_data = '0;
    if (rd_en) begin
      case (addr)
        ADDR_STATUS: begin
          read_data[STATUS_RUNNING_BIT] = running;
          read_data[STATUS_EXPIRED_BIT] = expired_reg;
        end
        ADDR_PRESCALER: begin
          read_data = prescaler_init;
        end
        ADDR_TIMER: begin
          read_data = timer_init;
        end
        ADDR_CURR: begin
          read_data = curr_timer;
        end
        // ctrl is write only and the rest is unmapped
        default: begin
          read_data = '0;
        end
      endcase
    end
  end

  // ----------------------------------------
  // assertions
  // ----------------------------------------

  // start_stop is a strict single pulse
  a_start_stop_pulse: assert property (
    @(posedge clk) disable iff (!reset_n)
    start_stop |=> !start_stop
  ) else $error("timer_regs: start_stop high on two consecutive cycles");

endmodule

/* hdl/timer_ctrl.sv */
`timescale 1ns/10ps

module timer_ctrl import timer_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_n,
  // toggle pulse from register block
  input  logic                   start_stop,
  // only checked for zero, to skip or reload the prescale phase
  input  logic [TIMER_WIDTH-1:0] prescaler_init,
  // zero flags from the two counters
  input  logic                   prescaler_zero,
  input  logic                   timer_zero,
  // counter controls
  output logic                   prescaler_load,
  output logic                   prescaler_dec,
  output logic                   timer_load,
  output logic                   timer_dec,
  // status to register block
  output logic                   running,
  output logic                   done
);

  ctrl_state_t state_reg;
  ctrl_state_t state_next;
  logic        prescale_skip;

  // no prescale phase at all when init is zero
  assign prescale_skip = (prescaler_init == '0);

  // ----------------------------------------
  // state register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state_reg <= CTRL_IDLE;
    end else begin
      state_reg <= state_next;
    end
  end

  // level, high in both active states
  assign running = (state_reg != CTRL_IDLE);

  // ----------------------------------------
  // next state and counter control
  // ----------------------------------------

  always_comb begin
    state_next     = state_reg;
    prescaler_load = 1'b0;
    prescaler_dec  = 1'b0;
    timer_load     = 1'b0;
    timer_dec      = 1'b0;
    done           = 1'b0;

    case (state_reg)
      CTRL_IDLE: begin
        if (start_stop) begin
          // both counters load together on start
          prescaler_load = 1'b1;
          timer_load     = 1'b1;
          if (prescale_skip) begin
            state_next = CTRL_COUNT;
          end else begin
            state_next = CTRL_PRESCALE;
          end
        end
      end

      CTRL_PRESCALE: begin
        if (start_stop) begin
          // stop, counts freeze where they are
          state_next = CTRL_IDLE;
        end else if (prescaler_zero) begin
          state_next = CTRL_COUNT;
        end else begin
          prescaler_dec = 1'b1;
        end
      end

      CTRL_COUNT: begin
        if (start_stop) begin
          state_next = CTRL_IDLE;
        end else if (timer_zero) begin
          // expiry, one cycle of done then idle
          done       = 1'b1;
          state_next = CTRL_IDLE;
        end else begin
          timer_dec = 1'b1;
          // reload for next tick unless prescaling is off
          if (!prescale_skip) begin
            prescaler_load = 1'b1;
            state_next     = CTRL_PRESCALE;
          end
        end
      end

      default: begin
        state_next = CTRL_IDLE;
      end
    endcase
  end

  // ----------------------------------------
  // assertions
  // ----------------------------------------

  // done only from count state, and the run is over next cycle
  a_done_in_count: assert property (
    @(posedge clk) disable iff (!reset_n)
    done |-> (state_reg == CTRL_COUNT) ##1 (state_reg == CTRL_IDLE && !running)
  ) else $error("timer_ctrl: done outside CTRL_COUNT or run kept going");

  // running only comes up after a start pulse seen in idle
  a_running_not_idle: assert property (
    @(posedge clk) disable iff (!reset_n)
    $rose(running) |-> ($past(start_stop) && $past(state_reg) == CTRL_IDLE)
  ) else $error("timer_ctrl: running high without start from CTRL_IDLE");

endmodule

/* hdl/timer_counter.sv */
`timescale 1ns/10ps

module timer_counter import timer_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_n,
  // control from timer_ctrl
  input  logic                   load,
  input  logic                   dec,
  // value taken on load
  input  logic [TIMER_WIDTH-1:0] init_value,
  // live count and zero flag back to controller
  output logic [TIMER_WIDTH-1:0] count,
  output logic                   zero
);

  // ----------------------------------------
  // count register
  // ----------------------------------------

  // load has priority over dec
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      count <= '0;
    end else if (load) begin
      count <= init_value;
    end else if (dec) begin
      count <= count - 1'b1;
    end
  end

  // zero reported straight from the register
  assign zero = (count == '0);

  // ----------------------------------------
  // assertions
  // ----------------------------------------

  // controller must pick one action per cycle
  a_no_load_and_dec: assert property (
    @(posedge clk) disable iff (!reset_n)
    !(load && dec)
  ) else $error("timer_counter: load and dec high together");

  // controller must never underflow the counter
  a_no_dec_at_zero: assert property (
    @(posedge clk) disable iff (!reset_n)
    dec |-> !zero
  ) else $error("timer_counter: dec while count is zero");

endmodule

/* hdl/timer_pkg.sv */
package timer_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  // prescaler, timer and host data path
  localparam int TIMER_WIDTH = 32;
  // host register address
  localparam int ADDR_WIDTH = 8;

  // ----------------------------------------
  // register bit positions
  // ----------------------------------------

  // ctrl register, write one to toggle run
  localparam int CTRL_START_BIT = 0;
  // status register fields
  localparam int STATUS_RUNNING_BIT = 0;
  localparam int STATUS_EXPIRED_BIT = 1;

  // ----------------------------------------
  // enums
  // ----------------------------------------

  // controller states
  typedef enum logic [1:0] {
    CTRL_IDLE     = 2'h0,
    CTRL_PRESCALE = 2'h1,
    CTRL_COUNT    = 2'h2
  } ctrl_state_t;

  // host register map, word addresses
  typedef enum logic [ADDR_WIDTH-1:0] {
    ADDR_CTRL      = 8'h08,
    ADDR_STATUS    = 8'h09,
    ADDR_PRESCALER = 8'h0a,
    ADDR_TIMER     = 8'h0b,
    ADDR_CURR      = 8'h0c
  } reg_addr_t;

endpackage
